/* txPkg.sv */
package txPkg;

	localparam int numChannels = 8;
	localparam int cmdWidth = 9;

	// command word bit positions
	// bits 0 and 3 were trigger LEDs and request timer
	localparam int cmdBitIssueRcv = 1;
	localparam int cmdBitFire = 2;
	localparam int cmdBitSetAmp = 4;
	localparam int cmdBitSetPhase = 5;
	localparam int cmdBitResetRcv = 6;
	localparam int cmdBitResetIrq = 7;

	// only modePio runs, RAM modes act as idle
	typedef enum logic [1:0]
	{
		modeIdle = 2'b00,
		modePio = 2'b01,
		modeRam = 2'b10,
		modePioRamSub = 2'b11
	} ctrlMode_t;

	typedef logic [8:0] chargeTime_t;	// pulse width, sets amplitude
	typedef logic [15:0] phaseDelay_t;
	typedef logic [22:0] fireDelay_t;
	typedef logic [31:0] rcvDelay_t;

	// one-cycle command pulses from the decoder
	typedef struct packed
	{
		logic issueRcv;
		logic fire;
		logic setAmp;
		logic setPhase;
		logic resetRcv;
		logic resetIrq;
	} cmdStrobe_t;

	typedef struct packed
	{
		chargeTime_t chargeTime;
		phaseDelay_t [numChannels-1:0] phaseDelay;
	} txSettings_t;

	// broadcast to every channel
	typedef struct packed
	{
		logic armed;
		logic trigger;
		logic clear;
	} channelCtrl_t;

endpackage

/* pioCmdDecode.sv */
`timescale 1ns/10ps

module pioCmdDecode import txPkg::*;
(
	input logic txCLK,
	input logic arstN,
	input ctrlMode_t mode,
	input logic [cmdWidth-1:0] pioCommand,
	output cmdStrobe_t strobes
);

	logic [cmdWidth-1:0] prevCmd;	// last word acted on
	logic cmdChanged;

	// the host only has to change the word to issue a command
	assign cmdChanged = (pioCommand != prevCmd);

	always_ff @(posedge txCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			prevCmd <= '0;
			strobes <= '0;
		end
		else if (mode != modePio)
		begin
			// forget the old word so the first command after return acts
			prevCmd <= '0;
			strobes <= '0;
		end
		else
		begin
			strobes <= '0;	// pulses last one cycle
			if (cmdChanged)
			begin
				prevCmd <= pioCommand;
				strobes.issueRcv <= pioCommand[cmdBitIssueRcv];
				strobes.fire <= pioCommand[cmdBitFire];
				strobes.setAmp <= pioCommand[cmdBitSetAmp];
				strobes.setPhase <= pioCommand[cmdBitSetPhase];
				strobes.resetRcv <= pioCommand[cmdBitResetRcv];
				strobes.resetIrq <= pioCommand[cmdBitResetIrq];
			end
		end
	end

endmodule

/* fireSequencer.sv */
`timescale 1ns/10ps

module fireSequencer import txPkg::*;
(
	input logic txCLK,
	input logic arstN,
	input ctrlMode_t mode,
	input cmdStrobe_t strobes,
	input chargeTime_t chargeTimeReg,
	input phaseDelay_t [numChannels-1:0] phaseDelayReg,
	input fireDelay_t fireDelay,
	input logic soloBoard,
	input logic externalTrigger,
	input logic [numChannels-1:0] channelDone,
	output txSettings_t settings,
	output channelCtrl_t chanCtrl,
	output logic cmdDoneIrq
);

	typedef enum logic [1:0]
	{
		seqIdle,
		seqDelay,
		seqArmed
	} seqState_t;

	seqState_t state;
	fireDelay_t delayCount;
	logic clearPulse;
	logic internalTrigger;	// solo board fires itself
	logic cmdSeen;		// fire or rcv issue since last irq reset
	logic fireBusy;
	logic allDone;
	logic syncCmd;

	assign fireBusy = (state != seqIdle);
	assign allDone = &channelDone;
	assign syncCmd = strobes.fire | strobes.issueRcv;

	assign chanCtrl = '{
		armed: (state == seqArmed),
		trigger: externalTrigger | internalTrigger,
		clear: clearPulse
	};

	// settings are frozen while a fire is running
	always_ff @(posedge txCLK or negedge arstN)
	begin
		if (!arstN)
			settings <= '0;
		else if (mode != modePio)
			settings <= '0;
		else if (!fireBusy)
		begin
			if (strobes.setAmp)
				settings.chargeTime <= chargeTimeReg;
			if (strobes.setPhase)
				settings.phaseDelay <= phaseDelayReg;
		end
	end

	always_ff @(posedge txCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= seqIdle;
			delayCount <= '0;
			clearPulse <= 1'b0;
		end
		else if (mode != modePio)
		begin
			state <= seqIdle;
			delayCount <= '0;
			clearPulse <= 1'b1;	// hold channels in wait
		end
		else
		begin
			clearPulse <= 1'b0;
			case (state)
				seqIdle:
					if (strobes.fire)
					begin
						delayCount <= fireDelay;
						state <= seqDelay;
					end
				seqDelay:
					if (delayCount != '0)
						delayCount <= delayCount - 1'b1;
					else
						state <= seqArmed;
				seqArmed:
					if (allDone)
					begin
						state <= seqIdle;
						clearPulse <= 1'b1;	// channels back to wait
					end
				default:
					state <= seqIdle;
			endcase
		end
	end

	// reset of the irq also drops the internal trigger
	always_ff @(posedge txCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			internalTrigger <= 1'b0;
			cmdSeen <= 1'b0;
			cmdDoneIrq <= 1'b0;
		end
		else if (mode != modePio || strobes.resetIrq)
		begin
			internalTrigger <= 1'b0;
			cmdSeen <= 1'b0;
			cmdDoneIrq <= 1'b0;
		end
		else
		begin
			if (syncCmd && soloBoard)
				internalTrigger <= 1'b1;
			if (syncCmd)
				cmdSeen <= 1'b1;
			if (cmdSeen && !fireBusy)
				cmdDoneIrq <= 1'b1;	// sticky until resetIrq
		end
	end

endmodule

/* rcvTrigger.sv */
`timescale 1ns/10ps

module rcvTrigger import txPkg::*;
(
	input logic txCLK,
	input logic arstN,
	input ctrlMode_t mode,
	input cmdStrobe_t strobes,
	input rcvDelay_t rcvDelay,
	input logic adcTriggerAck,
	output logic adcTrigger
);

	typedef enum logic [1:0]
	{
		rcvIdle,
		rcvCount,
		rcvFired
	} rcvState_t;

	rcvState_t state;
	rcvDelay_t delayCount;
	logic acked;	// blocks new issues until resetRcv
	logic issueOk;

	assign issueOk = strobes.issueRcv && !acked;
	assign adcTrigger = (state == rcvFired);

	always_ff @(posedge txCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= rcvIdle;
			delayCount <= '0;
			acked <= 1'b0;
		end
		else if (mode != modePio || strobes.resetRcv)
		begin
			// resetRcv wins over an issue in the same word
			state <= rcvIdle;
			delayCount <= '0;
			acked <= 1'b0;
		end
		else
		begin
			case (state)
				rcvIdle:
					if (issueOk)
					begin
						if (rcvDelay == '0)
							state <= rcvFired;	// no delay, line up at once
						else
						begin
							delayCount <= rcvDelay;
							state <= rcvCount;
						end
					end
				rcvCount:
					if (delayCount != '0)
						delayCount <= delayCount - 1'b1;
					else
						state <= rcvFired;
				rcvFired:
					if (adcTriggerAck)
					begin
						state <= rcvIdle;
						acked <= 1'b1;
					end
				default:
					state <= rcvIdle;
			endcase
		end
	end

endmodule

/* pulseChannel.sv */
`timescale 1ns/10ps

module pulseChannel import txPkg::*;
(
	input logic txCLK,
	input logic arstN,
	input logic active,
	input channelCtrl_t chanCtrl,
	input chargeTime_t chargeTime,
	input phaseDelay_t phaseDelay,
	output logic pulse,
	output logic done
);

	typedef enum logic [1:0]
	{
		chWait,
		chPhase,
		chCharge,
		chDone
	} chState_t;

	chState_t state;
	phaseDelay_t count;	// shared by phase and charge counting
	logic noPulse;

	assign noPulse = !active || (chargeTime == '0);
	assign pulse = (state == chCharge);
	assign done = (state == chDone);

	always_ff @(posedge txCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= chWait;
			count <= '0;
		end
		else if (chanCtrl.clear)
		begin
			state <= chWait;
			count <= '0;
		end
		else
		begin
			case (state)
				chWait:
					if (chanCtrl.armed)
					begin
						if (noPulse)
							state <= chDone;	// nothing to fire
						else if (chanCtrl.trigger)
						begin
							count <= phaseDelay;
							state <= chPhase;
						end
					end
				chPhase:
					if (count != '0)
						count <= count - 1'b1;
					else
					begin
						count <= phaseDelay_t'(chargeTime) - 1'b1;
						state <= chCharge;
					end
				chCharge:
					if (count != '0)
						count <= count - 1'b1;
					else
						state <= chDone;
				default:
					state <= state;	// done holds until clear
			endcase
		end
	end

endmodule

/* txOutputCtrl.sv */
`timescale 1ns/10ps

module txOutputCtrl import txPkg::*;
(
	input logic txCLK,
	input logic arstN,
	input ctrlMode_t mode,
	input logic [cmdWidth-1:0] pioCommand,
	input chargeTime_t chargeTimeReg,
	input phaseDelay_t [numChannels-1:0] phaseDelayReg,
	input fireDelay_t fireDelay,
	input rcvDelay_t rcvDelay,
	input logic [numChannels-1:0] channelActive,
	input logic soloBoard,
	input logic externalTrigger,
	input logic adcTriggerAck,
	output logic [numChannels-1:0] transducerOut,
	output logic adcTrigger,
	output logic cmdDoneIrq
);

	cmdStrobe_t strobes;
	txSettings_t settings;
	channelCtrl_t chanCtrl;
	logic [numChannels-1:0] channelDone;

	pioCmdDecode cmdDecode
	(
		.txCLK(txCLK),
		.arstN(arstN),
		.mode(mode),
		.pioCommand(pioCommand),
		.strobes(strobes)
	);

	fireSequencer sequencer
	(
		.txCLK(txCLK),
		.arstN(arstN),
		.mode(mode),
		.strobes(strobes),
		.chargeTimeReg(chargeTimeReg),
		.phaseDelayReg(phaseDelayReg),
		.fireDelay(fireDelay),
		.soloBoard(soloBoard),
		.externalTrigger(externalTrigger),
		.channelDone(channelDone),
		.settings(settings),
		.chanCtrl(chanCtrl),
		.cmdDoneIrq(cmdDoneIrq)
	);

	rcvTrigger adcTrig
	(
		.txCLK(txCLK),
		.arstN(arstN),
		.mode(mode),
		.strobes(strobes),
		.rcvDelay(rcvDelay),
		.adcTriggerAck(adcTriggerAck),
		.adcTrigger(adcTrigger)
	);

	// all channels share charge time and control, phase is per channel
	for (genvar i = 0; i < numChannels; i++)
	begin : genChannel
		pulseChannel channel
		(
			.txCLK(txCLK),
			.arstN(arstN),
			.active(channelActive[i]),
			.chanCtrl(chanCtrl),
			.chargeTime(settings.chargeTime),
			.phaseDelay(settings.phaseDelay[i]),
			.pulse(transducerOut[i]),
			.done(channelDone[i])
		);
	end

endmodule

/* txOutputCtrlTb.sv */
`timescale 1ns/10ps

module txOutputCtrlTb import txPkg::*;
();

	localparam int numRounds = 30;
	localparam int roundCycles = 200;	// worst case with every delay at max
	localparam logic [cmdWidth-1:0] cmdSetBoth = (9'd1 << cmdBitSetAmp) | (9'd1 << cmdBitSetPhase);
	localparam logic [cmdWidth-1:0] cmdFire = 9'd1 << cmdBitFire;
	localparam logic [cmdWidth-1:0] cmdIssue = 9'd1 << cmdBitIssueRcv;
	localparam logic [cmdWidth-1:0] cmdResetRcv = 9'd1 << cmdBitResetRcv;
	localparam logic [cmdWidth-1:0] cmdResetIrq = 9'd1 << cmdBitResetIrq;

	logic txCLK = 1'b0;
	logic arstN;
	ctrlMode_t mode;
	logic [cmdWidth-1:0] pioCommand;
	chargeTime_t chargeTimeReg;
	phaseDelay_t [numChannels-1:0] phaseDelayReg;
	fireDelay_t fireDelay;
	rcvDelay_t rcvDelay;
	logic [numChannels-1:0] channelActive;
	logic soloBoard;
	logic externalTrigger;
	logic adcTriggerAck;
	logic [numChannels-1:0] transducerOut;
	logic adcTrigger;
	logic cmdDoneIrq;

	int seed = 21638;
	int errors = 0;
	int checks = 0;
	int riseCount [numChannels];
	logic [numChannels-1:0] lastOut = '0;
	logic [numChannels-1:0] expOut;

	// reference model state
	logic [cmdWidth-1:0] mPrevCmd;
	logic [cmdWidth-1:0] mStb;	// word whose bits strobe this cycle
	chargeTime_t mCharge;
	phaseDelay_t mPhase [numChannels];
	int mSeq;	// 0 idle, 1 fire delay, 2 armed
	int mArmIn;
	logic mClr;
	logic mIntTrig;
	logic mCmdSeen;
	logic mIrq;
	int mChState [numChannels];	// 0 wait, 1 phase, 2 high, 3 done
	int mPhaseLeft [numChannels];
	int mHighLeft [numChannels];
	int mRcvState;	// 0 idle, 1 counting, 2 line high
	int mRcvLeft;
	logic mAcked;

	txOutputCtrl DUT
	(
		.txCLK(txCLK),
		.arstN(arstN),
		.mode(mode),
		.pioCommand(pioCommand),
		.chargeTimeReg(chargeTimeReg),
		.phaseDelayReg(phaseDelayReg),
		.fireDelay(fireDelay),
		.rcvDelay(rcvDelay),
		.channelActive(channelActive),
		.soloBoard(soloBoard),
		.externalTrigger(externalTrigger),
		.adcTriggerAck(adcTriggerAck),
		.transducerOut(transducerOut),
		.adcTrigger(adcTrigger),
		.cmdDoneIrq(cmdDoneIrq)
	);

	always #5 txCLK = ~txCLK;

	task automatic resetModel();
		mPrevCmd = '0;
		mStb = '0;
		mCharge = '0;
		mSeq = 0;
		mArmIn = 0;
		mClr = 1'b0;
		mIntTrig = 1'b0;
		mCmdSeen = 1'b0;
		mIrq = 1'b0;
		mRcvState = 0;
		mRcvLeft = 0;
		mAcked = 1'b0;
		for (int i = 0; i < numChannels; i++)
		begin
			mPhase[i] = '0;
			mChState[i] = 0;
			mPhaseLeft[i] = 0;
			mHighLeft[i] = 0;
		end
	endtask

	// every rule reads the state from before the edge
	task automatic advanceModel();
		logic allDone;
		logic armed;
		logic trig;
		logic seqIdle;
		logic pio;
		allDone = 1'b1;
		for (int i = 0; i < numChannels; i++)
			if (mChState[i] != 3)
				allDone = 1'b0;
		armed = (mSeq == 2);
		trig = externalTrigger | mIntTrig;
		seqIdle = (mSeq == 0);
		pio = (mode == modePio);
		for (int i = 0; i < numChannels; i++)
		begin
			if (mClr)
				mChState[i] = 0;
			else if (mChState[i] == 0 && armed)
			begin
				if (!channelActive[i] || mCharge == '0)
					mChState[i] = 3;	// nothing to fire so done at once
				else if (trig)
				begin
					mPhaseLeft[i] = int'(mPhase[i]) + 1;
					mChState[i] = 1;
				end
			end
			else if (mChState[i] == 1)
			begin
				mPhaseLeft[i]--;
				if (mPhaseLeft[i] == 0)
				begin
					mHighLeft[i] = int'(mCharge);
					mChState[i] = 2;
				end
			end
			else if (mChState[i] == 2)
			begin
				mHighLeft[i]--;
				if (mHighLeft[i] == 0)
					mChState[i] = 3;
			end
		end
		if (!pio || mStb[cmdBitResetRcv])
		begin
			mRcvState = 0;
			mAcked = 1'b0;
		end
		else if (mRcvState == 0 && mStb[cmdBitIssueRcv] && !mAcked)
		begin
			mRcvLeft = int'(rcvDelay) + 1;
			mRcvState = (rcvDelay == '0) ? 2 : 1;
		end
		else if (mRcvState == 1)
		begin
			mRcvLeft--;
			if (mRcvLeft == 0)
				mRcvState = 2;
		end
		else if (mRcvState == 2 && adcTriggerAck)
		begin
			mRcvState = 0;
			mAcked = 1'b1;
		end
		if (!pio || mStb[cmdBitResetIrq])
		begin
			mIntTrig = 1'b0;
			mCmdSeen = 1'b0;
			mIrq = 1'b0;
		end
		else
		begin
			if (mCmdSeen && seqIdle)
				mIrq = 1'b1;
			if (mStb[cmdBitFire] || mStb[cmdBitIssueRcv])
			begin
				mCmdSeen = 1'b1;
				if (soloBoard)
					mIntTrig = 1'b1;
			end
		end
		if (!pio)
		begin
			mCharge = '0;
			for (int i = 0; i < numChannels; i++)
				mPhase[i] = '0;
		end
		else if (seqIdle)
		begin
			if (mStb[cmdBitSetAmp])
				mCharge = chargeTimeReg;
			for (int i = 0; i < numChannels; i++)
				if (mStb[cmdBitSetPhase])
					mPhase[i] = phaseDelayReg[i];
		end
		mClr = !pio;	// channels held in wait outside PIO mode
		if (!pio)
			mSeq = 0;
		else if (mSeq == 0 && mStb[cmdBitFire])
		begin
			mSeq = 1;
			mArmIn = int'(fireDelay) + 1;
		end
		else if (mSeq == 1)
		begin
			mArmIn--;
			if (mArmIn == 0)
				mSeq = 2;
		end
		else if (mSeq == 2 && allDone)
		begin
			mSeq = 0;
			mClr = 1'b1;
		end
		if (!pio)
		begin
			mPrevCmd = '0;
			mStb = '0;
		end
		else if (pioCommand != mPrevCmd)
		begin
			mPrevCmd = pioCommand;
			mStb = pioCommand;	// acts only on a changed word
		end
		else
			mStb = '0;
	endtask

	always @(posedge txCLK)
	begin
		if (!arstN)
			resetModel();
		else
			advanceModel();
	end

	// outputs are settled by the falling edge
	always @(negedge txCLK)
	begin
		for (int i = 0; i < numChannels; i++)
		begin
			expOut[i] = (mChState[i] == 2);
			if (transducerOut[i] && !lastOut[i])
				riseCount[i]++;
		end
		lastOut = transducerOut;
		checks++;
		if (transducerOut !== expOut)
		begin
			errors++;
			$display("FAIL transducerOut: got %h, expected %h at %0t",
				transducerOut, expOut, $time);
		end
		if (adcTrigger !== (mRcvState == 2))
		begin
			errors++;
			$display("FAIL adcTrigger: got %h, expected %h at %0t",
				adcTrigger, mRcvState == 2, $time);
		end
		if (cmdDoneIrq !== mIrq)
		begin
			errors++;
			$display("FAIL cmdDoneIrq: got %h, expected %h at %0t",
				cmdDoneIrq, mIrq, $time);
		end
	end

	task automatic tick();
		@(posedge txCLK);
		#1;
	endtask

	task automatic sendCmd(input logic [cmdWidth-1:0] word);
		pioCommand = word;
		tick();
	endtask

	// adcLine selects adcTrigger instead of cmdDoneIrq
	task automatic waitHigh(input bit adcLine, input int limit);
		int n;
		n = 0;
		while ((adcLine ? adcTrigger : cmdDoneIrq) !== 1'b1 && n < limit)
		begin
			tick();
			n++;
		end
		if ((adcLine ? adcTrigger : cmdDoneIrq) !== 1'b1)
		begin
			errors++;
			$display("%s did not rise within %0d cycles", adcLine ? "adcTrigger" : "cmdDoneIrq", limit);
		end
	endtask

	task automatic ackPulse();
		adcTriggerAck = 1'b1;
		tick();
		adcTriggerAck = 1'b0;
	endtask

	task automatic runRound(input int r);
		bit dropMode;
		ctrlMode_t nonPio;
		logic [numChannels-1:0] expPulses;
		int n;
		dropMode = (r % 5 == 4);
		chargeTimeReg = chargeTime_t'({$random(seed)} % 16);
		for (int i = 0; i < numChannels; i++)
			phaseDelayReg[i] = phaseDelay_t'({$random(seed)} % 31);
		fireDelay = fireDelay_t'({$random(seed)} % 21);
		rcvDelay = rcvDelay_t'({$random(seed)} % 21);
		channelActive = numChannels'($random(seed));
		soloBoard = 1'($random(seed));
		sendCmd(cmdSetBoth);
		if (dropMode)
		begin
			// raise adcTrigger and the irq before leaving PIO mode
			sendCmd(cmdIssue);
			waitHigh(1'b1, 30);
			waitHigh(1'b0, 30);
			nonPio = ctrlMode_t'(2'({$random(seed)} % 3));
			if (nonPio == modePio)
				nonPio = modePioRamSub;
			mode = nonPio;
			repeat (3) tick();
			if (transducerOut !== '0 || adcTrigger !== 1'b0 || cmdDoneIrq !== 1'b0)
			begin
				errors++;
				$display("FAIL non-PIO outputs: transducerOut %h, adcTrigger %h, cmdDoneIrq %h",
					transducerOut, adcTrigger, cmdDoneIrq);
			end
			mode = modePio;
		end
		expPulses = (dropMode || chargeTimeReg == '0) ? '0 : channelActive;
		for (int i = 0; i < numChannels; i++)
			riseCount[i] = 0;
		sendCmd(cmdFire);
		sendCmd(cmdFire);	// same word again gives no second fire
		if (!soloBoard)
		begin
			n = 0;
			while (mSeq != 2 && n < 40)
			begin
				tick();
				n++;
			end
			externalTrigger = 1'b1;
			tick();
			externalTrigger = 1'b0;
		end
		waitHigh(1'b0, 80);
		repeat (3) tick();
		for (int i = 0; i < numChannels; i++)
			if (riseCount[i] != (expPulses[i] ? 1 : 0))
			begin
				errors++;
				$display("FAIL riseCount[%0d]: got %h, expected %h", i, riseCount[i], expPulses[i]);
			end
		sendCmd(cmdResetIrq);
		// receive trigger is blocked after ack until resetRcv
		sendCmd(cmdIssue);
		waitHigh(1'b1, 30);
		ackPulse();
		sendCmd(cmdIssue | 9'd1);
		repeat (25) tick();
		sendCmd(cmdResetRcv);
		sendCmd(cmdIssue);
		waitHigh(1'b1, 30);
		ackPulse();
		sendCmd(cmdResetRcv | cmdResetIrq);
		tick();
	endtask

	initial
	begin
		arstN = 1'b0;
		mode = modePio;
		pioCommand = '0;
		chargeTimeReg = '0;
		phaseDelayReg = '0;
		fireDelay = '0;
		rcvDelay = '0;
		channelActive = '0;
		soloBoard = 1'b0;
		externalTrigger = 1'b0;
		adcTriggerAck = 1'b0;
		resetModel();
		repeat (3) @(posedge txCLK);
		#1 arstN = 1'b1;
		tick();
		for (int r = 0; r < numRounds; r++)
			runRound(r);
		repeat (5) tick();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		#((numRounds * roundCycles + 50) * 10);
		$display("watchdog: run did not finish in time, checks: %0d, errors: %0d", checks, errors);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* all.f */
txPkg.sv
pioCmdDecode.sv
fireSequencer.sv
rcvTrigger.sv
pulseChannel.sv
txOutputCtrl.sv
txOutputCtrlTb.sv

/* run.sh */
#!/bin/bash
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f all.f --top-module txOutputCtrlTb -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
